// ==== direction_result.sv ====
`timescale 1ns/1ps

module direction_result #(
  // active pixels per line, sets the third boundaries
  parameter int line_width = 12,
  // fewest orange pixels that still count as a detection
  parameter int min_count  = 2
) (
  input  logic                 clk_25_vga,
  input  logic                 arst_n,
  input  orange_pkg::pixel_t   exe_pix,
  input  logic                 is_orange,
  output orange_pkg::verdict_t verdict,
  output logic                 verdict_valid
);

  localparam int cw = orange_pkg::col_w;
  localparam int nw = orange_pkg::cnt_w;

  // first column of the centre and of the right third
  localparam logic [cw-1:0] left_end   = cw'(line_width / 3);
  localparam logic [cw-1:0] center_end = cw'((2 * line_width) / 3);

  // detection threshold at count width
  localparam logic [nw-1:0] min_cnt = nw'(min_count);

  // running counts of the current line
  logic [nw-1:0] cnt_left;
  logic [nw-1:0] cnt_center;
  logic [nw-1:0] cnt_right;

  // which third the current sample lands in
  logic in_left;
  logic in_center;
  logic in_right;

  // counts with the current sample included
  logic [nw-1:0] sum_left;
  logic [nw-1:0] sum_center;
  logic [nw-1:0] sum_right;
  logic [nw-1:0] sum_total;

  // verdict built from the sums
  orange_pkg::verdict_t verdict_nxt;

  // sort by column, only orange pixels are counted
  assign in_left   = is_orange && (exe_pix.column < left_end);
  assign in_center = is_orange && (exe_pix.column >= left_end) &&
                     (exe_pix.column < center_end);
  assign in_right  = is_orange && (exe_pix.column >= center_end);

  // the line_end sample itself is folded in here
  assign sum_left   = cnt_left   + nw'(in_left);
  assign sum_center = cnt_center + nw'(in_center);
  assign sum_right  = cnt_right  + nw'(in_right);
  assign sum_total  = sum_left + sum_center + sum_right;

  always_comb begin
    verdict_nxt.count           = sum_total;
    verdict_nxt.orange_detected = (sum_total >= min_cnt);
    verdict_nxt.direction       = orange_pkg::dir_none;
    if (verdict_nxt.orange_detected) begin
      // largest third wins
      // centre takes every tie it is part of, left beats right
      if ((sum_center >= sum_left) && (sum_center >= sum_right)) begin
        verdict_nxt.direction = orange_pkg::dir_center;
      end else if (sum_left >= sum_right) begin
        verdict_nxt.direction = orange_pkg::dir_left;
      end else begin
        verdict_nxt.direction = orange_pkg::dir_right;
      end
    end
  end

  // per-third counters
  // cleared on the same edge that takes the verdict
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      cnt_left   <= '0;
      cnt_center <= '0;
      cnt_right  <= '0;
    end else if (exe_pix.line_end) begin
      cnt_left   <= '0;
      cnt_center <= '0;
      cnt_right  <= '0;
    end else begin
      cnt_left   <= sum_left;
      cnt_center <= sum_center;
      cnt_right  <= sum_right;
    end
  end

  // verdict holds between line ends, valid is a single pulse
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      verdict       <= '0;
      verdict_valid <= 1'b0;
    end else begin
      verdict_valid <= exe_pix.line_end;
      if (exe_pix.line_end) begin
        verdict <= verdict_nxt;
      end
    end
  end

endmodule

// ==== orange_execute.sv ====
`timescale 1ns/1ps

module orange_execute #(
  // colour window, all bounds inclusive
  parameter logic [7:0] red_min   = 8'hc0,
  parameter logic [7:0] green_min = 8'h40,
  parameter logic [7:0] green_max = 8'ha0,
  parameter logic [7:0] blue_max  = 8'h50
) (
  input  logic               clk_25_vga,
  input  logic               arst_n,
  input  orange_pkg::pixel_t dec_pix,
  output orange_pkg::pixel_t exe_pix,
  output logic               is_orange
);

  // per channel window tests
  logic red_ok;
  logic green_ok;
  logic blue_ok;

  // combined match for the incoming pixel
  logic hit;

  // pixel after marking, ahead of the register
  orange_pkg::pixel_t mark_pix;

  // strong red, moderate green, little blue
  assign red_ok   = (dec_pix.rgb.r >= red_min);
  assign green_ok = (dec_pix.rgb.g >= green_min) && (dec_pix.rgb.g <= green_max);
  assign blue_ok  = (dec_pix.rgb.b <= blue_max);

  // blanking samples never count, whatever their colour
  assign hit = dec_pix.active && red_ok && green_ok && blue_ok;

  // orange pixels are painted over, the rest keep their colour
  // column and flags pass unchanged
  always_comb begin
    mark_pix = dec_pix;
    if (hit) begin
      mark_pix.rgb = orange_pkg::mark_color;
    end
  end

  // execute register
  // is_orange is registered too so it lines up with exe_pix
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      exe_pix   <= '0;
      is_orange <= 1'b0;
    end else begin
      exe_pix   <= mark_pix;
      is_orange <= hit;
    end
  end

endmodule

// ==== orange_pkg.sv ====
package orange_pkg;

  // width of the per-line column counter
  localparam int col_w = 12;

  // width of the orange pixel counts, one bit wider than a column
  localparam int cnt_w = 13;

  // raw frame-buffer sample, red nibble in the top bits
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } pix12_t;

  // full colour, 8 bits per channel as sent to the display
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // one pixel moving down the pipeline
  // flags travel with the colour so every stage stays aligned
  typedef struct packed {
    rgb_t             rgb;
    logic             active;
    logic             line_end;
    logic [col_w-1:0] column;
  } pixel_t;

  // where the target sits on the line
  // dir_none when too few orange pixels were seen
  typedef enum logic [2:0] {
    dir_none,
    dir_left,
    dir_center,
    dir_right
  } direction_t;

  // per-line result handed on at each line end
  typedef struct packed {
    logic             orange_detected;
    direction_t       direction;
    logic [cnt_w-1:0] count;
  } verdict_t;

  // colour painted over every orange pixel, full green
  localparam rgb_t mark_color = '{r: 8'h00, g: 8'hff, b: 8'h00};

endpackage

// ==== orange_trace.txt ====
# P active line_end rddata(hex) expected_pix_out(hex)
# V orange_detected direction(0 none 1 left 2 centre 3 right) count(hex)
P 1 0 c40 00ff00
P 1 0 c90 00ff00
P 1 0 c44 00ff00
P 1 0 b40 bb4400
P 1 0 c30 cc3300
P 1 0 ca0 ccaa00
P 1 0 c45 cc4455
P 1 1 f84 00ff00
V 1 1 4
P 1 0 123 112233
P 1 0 f84 00ff00
P 1 0 456 445566
P 1 0 000 000000
P 1 0 f84 00ff00
P 1 0 f84 00ff00
P 1 0 d95 dd9955
P 0 1 fff 000000
V 1 2 3
P 1 0 f84 00ff00
P 1 0 222 222222
P 1 0 333 333333
P 1 0 777 777777
P 1 0 f84 00ff00
P 1 0 888 888888
P 1 0 999 999999
P 1 0 aaa aaaaaa
P 1 0 f84 00ff00
P 1 1 e94 00ff00
V 1 3 4
P 1 1 f84 00ff00
V 0 0 1
P 1 0 f84 00ff00
P 1 0 111 111111
P 1 0 555 555555
P 1 0 666 666666
P 1 1 f84 00ff00
V 1 2 2

// ==== orange_tracker.f ====
orange_pkg.sv
pixel_decode.sv
orange_execute.sv
direction_result.sv
orange_tracker.sv
tb_orange_tracker.sv

// ==== orange_tracker.sv ====
`timescale 1ns/1ps

module orange_tracker #(
  // orange colour window
  parameter logic [7:0] red_min    = 8'hc0,
  parameter logic [7:0] green_min  = 8'h40,
  parameter logic [7:0] green_max  = 8'ha0,
  parameter logic [7:0] blue_max   = 8'h50,
  // line geometry and detection threshold
  parameter int         line_width = 12,
  parameter int         min_count  = 2
) (
  input  logic                 clk_25_vga,
  input  logic                 arst_n,
  input  orange_pkg::pix12_t   rddata,
  input  logic                 active,
  input  logic                 line_end,
  output orange_pkg::rgb_t     pix_out,
  output logic                 pix_active,
  output orange_pkg::verdict_t verdict,
  output logic                 verdict_valid
);

  // decode to execute
  orange_pkg::pixel_t dec_pix;

  // execute to result and display
  orange_pkg::pixel_t exe_pix;
  logic               is_orange;

  // stage 1, colour expansion and column count
  pixel_decode pixel_decode_i (
    .clk_25_vga (clk_25_vga),
    .arst_n     (arst_n),
    .rddata     (rddata),
    .active     (active),
    .line_end   (line_end),
    .dec_pix    (dec_pix)
  );

  // stage 2, colour window test and marking
  orange_execute #(
    .red_min   (red_min),
    .green_min (green_min),
    .green_max (green_max),
    .blue_max  (blue_max)
  ) orange_execute_i (
    .clk_25_vga (clk_25_vga),
    .arst_n     (arst_n),
    .dec_pix    (dec_pix),
    .exe_pix    (exe_pix),
    .is_orange  (is_orange)
  );

  // stage 3, per-line direction verdict
  direction_result #(
    .line_width (line_width),
    .min_count  (min_count)
  ) direction_result_i (
    .clk_25_vga    (clk_25_vga),
    .arst_n        (arst_n),
    .exe_pix       (exe_pix),
    .is_orange     (is_orange),
    .verdict       (verdict),
    .verdict_valid (verdict_valid)
  );

  // marked stream goes straight on to the display
  assign pix_out    = exe_pix.rgb;
  assign pix_active = exe_pix.active;

endmodule

// ==== pixel_decode.sv ====
`timescale 1ns/1ps

module pixel_decode (
  input  logic               clk_25_vga,
  input  logic               arst_n,
  input  orange_pkg::pix12_t rddata,
  input  logic               active,
  input  logic               line_end,
  output orange_pkg::pixel_t dec_pix
);

  // column of the current sample within its line
  logic [orange_pkg::col_w-1:0] column;

  // expanded colour before the register
  orange_pkg::rgb_t             rgb_exp;

  // next value of the column counter
  logic [orange_pkg::col_w-1:0] column_nxt;

  // each 4-bit nibble goes to both halves of its byte
  // so 4'hf maps to 8'hff and 4'h0 to 8'h00
  always_comb begin
    rgb_exp.r = {rddata.r, rddata.r};
    rgb_exp.g = {rddata.g, rddata.g};
    rgb_exp.b = {rddata.b, rddata.b};
    // blanking area carries no colour
    if (!active) begin
      rgb_exp = '0;
    end
  end

  // counter moves on active samples only
  // line_end restarts it for the next line, even with active low
  always_comb begin
    column_nxt = column;
    if (line_end) begin
      column_nxt = '0;
    end else if (active) begin
      column_nxt = column + 1'b1;
    end
  end

  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      column <= '0;
    end else begin
      column <= column_nxt;
    end
  end

  // decode register, one cycle of latency
  // the sample is stamped with the column it arrived at
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      dec_pix <= '0;
    end else begin
      dec_pix.rgb      <= rgb_exp;
      dec_pix.active   <= active;
      dec_pix.line_end <= line_end;
      dec_pix.column   <= column;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --top-module tb_orange_tracker -f orange_tracker.f \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_orange_tracker > sim.log 2>&1
cat sim.log
# the log decides, a missing pass line counts as a failure too
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || exit 1
exit 0

// ==== tb_orange_tracker.sv ====
`timescale 1ns/1ps

module tb_orange_tracker;

  // DUT ports
  logic                 clk_25_vga;
  logic                 arst_n;
  orange_pkg::pix12_t   rddata;
  logic                 active;
  logic                 line_end;
  orange_pkg::rgb_t     pix_out;
  logic                 pix_active;
  orange_pkg::verdict_t verdict;
  logic                 verdict_valid;

  // steps since reset release, one per clock
  int cycle;
  // step at which the last line_end was driven
  int le_cycle;
  // verdict the outputs must hold between pulses
  orange_pkg::verdict_t last_verdict;

  // pixel expectations in flight, oldest first
  orange_pkg::rgb_t exp_rgb_q[$];
  logic             exp_act_q[$];
  int               due_q[$];

  // window bounds sit on nibble-expanded levels
  // so trace pixels land exactly on each bound and one step outside it
  orange_tracker #(
    .red_min   (8'hcc),
    .green_min (8'h44),
    .green_max (8'h99),
    .blue_max  (8'h44)
  ) orange_tracker_i (
    .clk_25_vga    (clk_25_vga),
    .arst_n        (arst_n),
    .rddata        (rddata),
    .active        (active),
    .line_end      (line_end),
    .pix_out       (pix_out),
    .pix_active    (pix_active),
    .verdict       (verdict),
    .verdict_valid (verdict_valid)
  );

  // 4 ns period
  initial begin
    clk_25_vga = 1'b0;
    forever begin
      #2 clk_25_vga = ~clk_25_vga;
    end
  end

  task automatic stop_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_pixel(input orange_pkg::rgb_t got, input orange_pkg::rgb_t exp);
    if (got !== exp) begin
      $display("[ERROR] pix_out: got 0x%h expected 0x%h", got, exp);
      stop_run();
    end
  endtask

  task automatic check_verdict(input orange_pkg::verdict_t got,
                               input orange_pkg::verdict_t exp);
    if (got !== exp) begin
      $display("[ERROR] verdict: got 0x%h expected 0x%h", got, exp);
      stop_run();
    end
  endtask

  // single-bit levels such as pix_active and verdict_valid
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  // advance one clock, sample 1 ns after the edge where outputs are settled
  task automatic step_cycle();
    orange_pkg::rgb_t e_rgb;
    logic             e_act;
    @(posedge clk_25_vga);
    #1;
    cycle = cycle + 1;
    // each sample leaves the pipeline exactly 2 steps after it was driven
    if (due_q.size() > 0 && due_q[0] == cycle) begin
      e_rgb = exp_rgb_q.pop_front();
      e_act = exp_act_q.pop_front();
      due_q.delete(0);
      check_pixel(pix_out, e_rgb);
      check_bit("pix_active", pix_active, e_act);
    end
    // valid may only pulse 3 steps after a line end
    if (verdict_valid && cycle != le_cycle + 3) begin
      $display("verdict_valid pulsed at step %0d but the last line end was at step %0d",
               cycle, le_cycle);
      stop_run();
    end
    // verdict holds its last value outside the pulse
    if (cycle != le_cycle + 3) begin
      check_verdict(verdict, last_verdict);
    end
  endtask

  task automatic drive_sample(input logic act, input logic le,
                              input orange_pkg::pix12_t rd, input orange_pkg::rgb_t exp_rgb);
    active   = act;
    line_end = le;
    rddata   = rd;
    exp_rgb_q.push_back(exp_rgb);
    exp_act_q.push_back(act);
    due_q.push_back(cycle + 2);
    if (le) begin
      le_cycle = cycle;
    end
  endtask

  // blanking sample, comes out as black and inactive
  task automatic drive_idle();
    drive_sample(1'b0, 1'b0, '0, '0);
  endtask

  // keep the stream idle until the verdict pulse shows up
  task automatic wait_verdict(input orange_pkg::verdict_t exp);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < 8) begin
      step_cycle();
      seen = verdict_valid;
      drive_idle();
      waited++;
    end
    if (!seen) begin
      $display("timeout, verdict_valid did not pulse within 8 cycles of line end");
      stop_run();
    end
    check_verdict(verdict, exp);
    last_verdict = exp;
  endtask

  initial begin
    int                   fd;
    int                   code;
    int                   gap;
    int                   waited;
    logic [7:0]           tag;
    logic [8*200-1:0]     rest;
    logic                 f_act;
    logic                 f_le;
    logic [11:0]          f_rd;
    logic [23:0]          f_rgb;
    logic                 f_det;
    logic [2:0]           f_dir;
    logic [12:0]          f_cnt;
    orange_pkg::verdict_t exp_v;

    arst_n       = 1'b0;
    rddata       = '0;
    active       = 1'b0;
    line_end     = 1'b0;
    cycle        = 0;
    le_cycle     = -100;
    last_verdict = '0;
    gap          = $urandom(32'h8605_3177);

    repeat (2) @(posedge clk_25_vga);
    #1;
    arst_n = 1'b1;
    // outputs come out of reset idle with an all-zero verdict
    check_bit("verdict_valid", verdict_valid, 1'b0);
    check_bit("pix_active", pix_active, 1'b0);
    check_verdict(verdict, '0);

    fd = $fopen("orange_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file orange_trace.txt");
      stop_run();
    end

    code = $fscanf(fd, "%s", tag);
    while (code == 1) begin
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "P") begin
        code = $fscanf(fd, "%h %h %h %h", f_act, f_le, f_rd, f_rgb);
        if (code != 4) begin
          $display("pixel record in the trace file is incomplete");
          stop_run();
        end
        // pixels of a line go back to back
        step_cycle();
        drive_sample(f_act, f_le, f_rd, f_rgb);
      end else if (tag == "V") begin
        code = $fscanf(fd, "%h %h %h", f_det, f_dir, f_cnt);
        if (code != 3) begin
          $display("verdict record in the trace file is incomplete");
          stop_run();
        end
        exp_v.orange_detected = f_det;
        exp_v.direction       = orange_pkg::direction_t'(f_dir);
        exp_v.count           = f_cnt;
        wait_verdict(exp_v);
        // a few extra blanking cycles before the next line
        gap = $urandom % 3;
        repeat (gap) begin
          step_cycle();
          drive_idle();
        end
      end else begin
        $display("trace file holds a record of unknown kind");
        stop_run();
      end
      code = $fscanf(fd, "%s", tag);
    end
    $fclose(fd);

    // flush the samples still in the pipeline
    waited = 0;
    while (due_q.size() > 0 && waited < 8) begin
      step_cycle();
      waited++;
    end
    if (due_q.size() > 0) begin
      $display("pixels still unchecked after the last line");
      stop_run();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule
